// ==== flist.f ====
logic/dm_pkg.sv
logic/dmi_req_decode.sv
logic/dm_ctrl_regs.sv
logic/dm_abstract_regs.sv
logic/dmi_resp_queue.sv
logic/dm_csrs_top.sv
tb/tb_dm_csrs.sv

// ==== logic/dm_abstract_regs.sv ====
`timescale 1ns/1ps

module dm_abstract_regs import dm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dm_stage_t               stage_i,
  input  dmi_resp_t               resp_i,
  input  logic                    dmactive_i,
  input  logic                    cmdbusy_i,
  input  logic                    cmderror_valid_i,
  input  cmderr_e                 cmderror_i,
  input  logic                    data_valid_i,
  input  word_t [DataCount-1:0]   data_i,
  output dmi_resp_t               resp_o,
  output logic                    cmd_valid_o,
  output command_t                cmd_o,
  output word_t [DataCount-1:0]   data_o,
  output word_t [ProgBufSize-1:0] progbuf_o
);

  logic                           rd, wr;
  logic                           busy_hit;
  logic [$clog2(DataCount)-1:0]   data_idx;
  logic [$clog2(ProgBufSize)-1:0] pb_idx;
  word_t                          abstractcs;

  cmderr_e                 cmderr_d, cmderr_q;
  command_t                command_d, command_q;
  abstractauto_t           abstractauto_d, abstractauto_q;
  logic                    cmd_valid_d, cmd_valid_q;
  word_t [DataCount-1:0]   data_d, data_q;
  word_t [ProgBufSize-1:0] progbuf_d, progbuf_q;

  assign rd       = stage_i.valid && stage_i.op == DTM_READ;
  assign wr       = stage_i.valid && stage_i.op == DTM_WRITE;
  assign data_idx = stage_i.idx[$clog2(DataCount)-1:0];
  assign pb_idx   = stage_i.idx[$clog2(ProgBufSize)-1:0];

  assign abstractcs = {3'b0, 5'(ProgBufSize), 11'b0, cmdbusy_i, 1'b0, cmderr_q,
                       4'b0, 4'(DataCount)};

  // accesses refused while a command runs
  always_comb begin
    case (stage_i.cls)
      ClassData, ClassProgBuf:             busy_hit = cmdbusy_i && (rd || wr);
      ClassAbsCs, ClassCommand, ClassAuto: busy_hit = cmdbusy_i && wr;
      default:                             busy_hit = 1'b0;
    endcase
  end

  // ------------------------------
  // register access
  // ------------------------------
  always_comb begin
    cmderr_d       = cmderr_q;
    command_d      = command_q;
    abstractauto_d = abstractauto_q;
    data_d         = data_q;
    progbuf_d      = progbuf_q;
    cmd_valid_d    = 1'b0;
    resp_o         = resp_i;

    if (busy_hit) begin
      resp_o.resp = DTM_BUSY;
      if (cmderr_q == CmdErrNone) begin
        cmderr_d = CmdErrBusy;
      end
    end else if (rd || wr) begin
      case (stage_i.cls)
        ClassData: begin
          if (rd) begin
            resp_o.data = data_q[data_idx];
          end else begin
            data_d[data_idx] = stage_i.data;
          end
          cmd_valid_d = abstractauto_q.autoexecdata[stage_i.idx];
        end
        ClassProgBuf: begin
          if (rd) begin
            resp_o.data = progbuf_q[pb_idx];
          end else begin
            progbuf_d[pb_idx] = stage_i.data;
          end
          cmd_valid_d = abstractauto_q.autoexecprogbuf[stage_i.idx];
        end
        ClassAbsCs: begin
          if (rd) begin
            resp_o.data = abstractcs;
          end else begin
            // cmderr is write-one-to-clear
            cmderr_d = cmderr_e'(cmderr_q & ~stage_i.data[10:8]);
          end
        end
        ClassCommand: begin
          if (wr) begin
            command_d   = command_t'(stage_i.data);
            cmd_valid_d = 1'b1;
          end
        end
        ClassAuto: begin
          if (rd) begin
            resp_o.data = abstractauto_q;
          end else begin
            abstractauto_d                 = '0;
            abstractauto_d.autoexecdata    = 12'(stage_i.data[DataCount-1:0]);
            abstractauto_d.autoexecprogbuf = 16'(stage_i.data[16 +: ProgBufSize]);
          end
        end
        default: ;
      endcase
    end

    // hart side wins over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q       <= CmdErrNone;
      command_q      <= '0;
      abstractauto_q <= '0;
      cmd_valid_q    <= 1'b0;
      data_q         <= '0;
      progbuf_q      <= '0;
    end else if (!dmactive_i) begin
      // synchronous clear while the module is inactive
      cmderr_q       <= CmdErrNone;
      command_q      <= '0;
      abstractauto_q <= '0;
      cmd_valid_q    <= 1'b0;
      data_q         <= '0;
      progbuf_q      <= '0;
    end else begin
      cmderr_q       <= cmderr_d;
      command_q      <= command_d;
      abstractauto_q <= abstractauto_d;
      cmd_valid_q    <= cmd_valid_d;
      data_q         <= data_d;
      progbuf_q      <= progbuf_d;
    end
  end

endmodule

// ==== logic/dm_csrs_top.sv ====
`timescale 1ns/1ps

module dm_csrs_top import dm_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    dmi_rst_ni,
  // ------------------------------
  // DMI
  // ------------------------------
  input  logic                    dmi_req_valid_i,
  output logic                    dmi_req_ready_o,
  input  dmi_req_t                dmi_req_i,
  output logic                    dmi_resp_valid_o,
  input  logic                    dmi_resp_ready_i,
  output dmi_resp_t               dmi_resp_o,
  // global control
  output logic                    ndmreset_o,
  output logic                    dmactive_o,
  // hart status and control
  input  hart_vec_t               halted_i,
  input  hart_vec_t               unavailable_i,
  input  hart_vec_t               resumeack_i,
  output hartsel_t                hartsel_o,
  output hart_vec_t               haltreq_o,
  output hart_vec_t               resumereq_o,
  output logic                    clear_resumeack_o,
  // abstract commands
  output logic                    cmd_valid_o,
  output command_t                cmd_o,
  input  logic                    cmderror_valid_i,
  input  cmderr_e                 cmderror_i,
  input  logic                    cmdbusy_i,
  output word_t [ProgBufSize-1:0] progbuf_o,
  output word_t [DataCount-1:0]   data_o,
  input  word_t [DataCount-1:0]   data_i,
  input  logic                    data_valid_i
);

  dm_stage_t stage;
  dmi_resp_t ctrl_resp;
  dmi_resp_t final_resp;

  dmi_req_decode u_decode (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dmi_rst_ni      (dmi_rst_ni),
    .dmi_req_valid_i (dmi_req_valid_i),
    .dmi_req_ready_i (dmi_req_ready_o),
    .dmi_req_i       (dmi_req_i),
    .stage_o         (stage)
  );

  dm_ctrl_regs u_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .stage_i           (stage),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .resp_o            (ctrl_resp),
    .hartsel_o         (hartsel_o),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .clear_resumeack_o (clear_resumeack_o)
  );

  dm_abstract_regs u_abstract (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .stage_i          (stage),
    .resp_i           (ctrl_resp),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .resp_o           (final_resp),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .progbuf_o        (progbuf_o)
  );

  // one response per stage entry
  dmi_resp_queue u_resp_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_rst_ni       (dmi_rst_ni),
    .push_i           (stage.valid),
    .resp_i           (final_resp),
    .stage_valid_i    (stage.valid),
    .req_ready_o      (dmi_req_ready_o),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_o       (dmi_resp_o)
  );

endmodule

// ==== logic/dm_ctrl_regs.sv ====
`timescale 1ns/1ps

module dm_ctrl_regs import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  dm_stage_t stage_i,
  input  hart_vec_t halted_i,
  input  hart_vec_t unavailable_i,
  input  hart_vec_t resumeack_i,
  output dmi_resp_t resp_o,
  output hartsel_t  hartsel_o,
  output hart_vec_t haltreq_o,
  output hart_vec_t resumereq_o,
  output logic      ndmreset_o,
  output logic      dmactive_o,
  output logic      clear_resumeack_o
);

  dmcontrol_t dmcontrol_d, dmcontrol_q;
  dmcontrol_t wr_ctrl;
  dmstatus_t  dmstatus;
  hart_vec_t  havereset_d, havereset_q;
  hart_vec_t  sel_mask;
  hart_vec_t  wr_mask;
  logic       ctrl_write;

  assign ctrl_write = stage_i.valid && stage_i.op == DTM_WRITE && stage_i.cls == ClassCtrl;
  assign wr_ctrl    = dmcontrol_t'(stage_i.data);
  assign hartsel_o  = hartsel_t'(dmcontrol_q.hartsello);

  // one-hot hart select, empty when the hart does not exist
  assign sel_mask = hart_vec_t'(1) << hartsel_o;
  assign wr_mask  = hart_vec_t'(1) << hartsel_t'(wr_ctrl.hartsello);

  // ------------------------------
  // dmcontrol and havereset
  // ------------------------------
  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    havereset_d       = havereset_q;
    clear_resumeack_o = 1'b0;

    if (ctrl_write) begin
      dmcontrol_d           = '0;
      dmcontrol_d.haltreq   = wr_ctrl.haltreq;
      dmcontrol_d.resumereq = wr_ctrl.resumereq;
      // hartsel is WARL, upper bits read as zero
      dmcontrol_d.hartsello = 10'(hartsel_t'(wr_ctrl.hartsello));
      dmcontrol_d.ndmreset  = wr_ctrl.ndmreset;
      dmcontrol_d.dmactive  = wr_ctrl.dmactive;
      if (wr_ctrl.ackhavereset) begin
        havereset_d = havereset_q & ~wr_mask;
      end
    end

    // new resume request, so the old ack goes away
    if (!dmcontrol_q.resumereq && dmcontrol_d.resumereq) begin
      clear_resumeack_o = 1'b1;
    end
    if (dmcontrol_q.resumereq && |(resumeack_i & sel_mask)) begin
      dmcontrol_d.resumereq = 1'b0;
    end

    if (ndmreset_o) begin
      havereset_d = '1;
    end
  end

  // status of the selected hart
  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = DbgVersion013;
    dmstatus.authenticated  = 1'b1;
    dmstatus.allhavereset   = |(havereset_q & sel_mask);
    dmstatus.anyhavereset   = |(havereset_q & sel_mask);
    dmstatus.allresumeack   = |(resumeack_i & sel_mask);
    dmstatus.anyresumeack   = |(resumeack_i & sel_mask);
    dmstatus.allnonexistent = 32'(hartsel_o) >= NrHarts;
    dmstatus.anynonexistent = 32'(hartsel_o) >= NrHarts;
    dmstatus.allunavail     = |(unavailable_i & sel_mask);
    dmstatus.anyunavail     = |(unavailable_i & sel_mask);
    // unavailable harts are neither halted nor running
    dmstatus.allhalted      = |(halted_i & ~unavailable_i & sel_mask);
    dmstatus.anyhalted      = |(halted_i & ~unavailable_i & sel_mask);
    dmstatus.allrunning     = |(~halted_i & ~unavailable_i & sel_mask);
    dmstatus.anyrunning     = |(~halted_i & ~unavailable_i & sel_mask);
  end

  // read data for the control classes
  always_comb begin
    resp_o = '{data: '0, resp: DTM_SUCCESS};
    if (stage_i.valid && stage_i.op == DTM_READ) begin
      case (stage_i.cls)
        ClassCtrl:    resp_o.data = dmcontrol_q;
        ClassStatus:  resp_o.data = dmstatus;
        ClassHaltSum: resp_o.data = word_t'(halted_i);
        default:      resp_o.data = '0;
      endcase
    end
  end

  assign haltreq_o   = {NrHarts{dmcontrol_q.haltreq}} & sel_mask;
  assign resumereq_o = {NrHarts{dmcontrol_q.resumereq}} & sel_mask;
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      if (!dmcontrol_q.dmactive) begin
        // inactive module, dmactive is the only live bit
        dmcontrol_q <= '{dmactive: dmcontrol_d.dmactive, default: '0};
      end else begin
        dmcontrol_q <= dmcontrol_d;
      end
    end
  end

endmodule

// ==== logic/dm_pkg.sv ====
package dm_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int unsigned NrHarts     = 3;
  localparam int unsigned HartSelLen  = 2;
  localparam int unsigned DataCount   = 2;
  localparam int unsigned ProgBufSize = 4;
  localparam int unsigned RespDepth   = 2;

  typedef logic [6:0]            dmi_addr_t;
  typedef logic [31:0]           word_t;
  typedef logic [NrHarts-1:0]    hart_vec_t;
  typedef logic [HartSelLen-1:0] hartsel_t;

  // ------------------------------
  // register map
  // ------------------------------
  localparam dmi_addr_t AddrData0        = 7'h04;
  localparam dmi_addr_t AddrDmControl    = 7'h10;
  localparam dmi_addr_t AddrDmStatus     = 7'h11;
  localparam dmi_addr_t AddrHaltSum0     = 7'h40;
  localparam dmi_addr_t AddrAbstractCs   = 7'h16;
  localparam dmi_addr_t AddrCommand      = 7'h17;
  localparam dmi_addr_t AddrAbstractAuto = 7'h18;
  localparam dmi_addr_t AddrProgBuf0     = 7'h20;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion013 = 4'd2;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_FAILED  = 2'h2,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // nine classes, so one bit more than a 3-bit code holds
  typedef enum logic [3:0] {
    ClassCtrl,
    ClassStatus,
    ClassHaltSum,
    ClassAbsCs,
    ClassCommand,
    ClassAuto,
    ClassData,
    ClassProgBuf,
    ClassNone
  } reg_class_e;

  // ------------------------------
  // bus and stage records
  // ------------------------------
  typedef struct packed {
    dmi_addr_t addr;
    dtm_op_e   op;
    word_t     data;
  } dmi_req_t;

  typedef struct packed {
    word_t     data;
    dtm_resp_e resp;
  } dmi_resp_t;

  typedef struct packed {
    logic       valid;
    dtm_op_e    op;
    reg_class_e cls;
    logic [1:0] idx;
    word_t      data;
  } dm_stage_t;

  // ------------------------------
  // register layouts
  // ------------------------------
  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       zero2;
    logic       ackhavereset;
    logic [1:0] zero1;
    logic [9:0] hartsello;
    logic [13:0] zero0;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       devtreevalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  typedef struct packed {
    logic [15:0] autoexecprogbuf;
    logic [3:0]  zero0;
    logic [11:0] autoexecdata;
  } abstractauto_t;

endpackage

// ==== logic/dmi_req_decode.sv ====
`timescale 1ns/1ps

module dmi_req_decode import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      dmi_rst_ni,
  input  logic      dmi_req_valid_i,
  input  logic      dmi_req_ready_i,
  input  dmi_req_t  dmi_req_i,
  output dm_stage_t stage_o
);

  logic      accept;
  dm_stage_t stage_d;

  assign accept = dmi_req_valid_i & dmi_req_ready_i;

  // address to register class and array index
  always_comb begin
    stage_d       = '0;
    stage_d.valid = accept;
    stage_d.op    = dmi_req_i.op;
    stage_d.data  = dmi_req_i.data;
    case (dmi_req_i.addr) inside
      [AddrData0 : AddrData0 + dmi_addr_t'(DataCount - 1)]: begin
        stage_d.cls = ClassData;
        stage_d.idx = 2'(dmi_req_i.addr - AddrData0);
      end
      [AddrProgBuf0 : AddrProgBuf0 + dmi_addr_t'(ProgBufSize - 1)]: begin
        stage_d.cls = ClassProgBuf;
        stage_d.idx = 2'(dmi_req_i.addr - AddrProgBuf0);
      end
      AddrDmControl:    stage_d.cls = ClassCtrl;
      AddrDmStatus:     stage_d.cls = ClassStatus;
      AddrHaltSum0:     stage_d.cls = ClassHaltSum;
      AddrAbstractCs:   stage_d.cls = ClassAbsCs;
      AddrCommand:      stage_d.cls = ClassCommand;
      AddrAbstractAuto: stage_d.cls = ClassAuto;
      default:          stage_d.cls = ClassNone;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_o <= '0;
    end else if (!dmi_rst_ni) begin
      // DTM reset drops the request in flight
      stage_o <= '0;
    end else begin
      stage_o <= stage_d;
    end
  end

endmodule

// ==== logic/dmi_resp_queue.sv ====
`timescale 1ns/1ps

module dmi_resp_queue import dm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      dmi_rst_ni,
  input  logic      push_i,
  input  dmi_resp_t resp_i,
  input  logic      stage_valid_i,
  output logic      req_ready_o,
  output logic      dmi_resp_valid_o,
  input  logic      dmi_resp_ready_i,
  output dmi_resp_t dmi_resp_o
);

  dmi_resp_t                        mem_q [RespDepth];
  logic [$clog2(RespDepth)-1:0]     wr_ptr_q, rd_ptr_q;
  logic [$clog2(RespDepth+1)-1:0]   count_q;
  logic                             pop;

  assign dmi_resp_valid_o = count_q != '0;
  assign dmi_resp_o       = mem_q[rd_ptr_q];
  assign pop              = dmi_resp_ready_i & dmi_resp_valid_o;

  // keep a slot for the request still in the stage
  assign req_ready_o = (RespDepth - 32'(count_q)) > 32'(stage_valid_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (!dmi_rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (32'(wr_ptr_q) == RespDepth - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (32'(rd_ptr_q) == RespDepth - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push_i - pop;
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= resp_i;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DMI register block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dm_csrs -Mdir obj_dir -o sim_tb_dm_csrs \
  -f flist.f

./obj_dir/sim_tb_dm_csrs | tee sim.log

if grep -q "Everything OK" sim.log; then
  exit 0
fi
exit 1

// ==== tb/tb_dm_csrs.sv ====
`timescale 1ns/1ps

module tb_dm_csrs import dm_pkg::*; ();

  typedef struct packed {
    dtm_op_e   op;
    dmi_addr_t addr;
    word_t     wdata;
    logic      busy;
    hart_vec_t halted;
    hart_vec_t rack;
    logic [3:0] herr;    // bit 3 is the report valid, bits 2:0 the code
    logic      hdv;
    dtm_resp_e resp;
    word_t     data;
    logic      cmd;
    logic      clr;
    logic      chk_req;
    hart_vec_t hreq;
    hart_vec_t rreq;
  } test_t;

  typedef struct packed {
    logic [7:0] idx;
    dtm_resp_e  resp;
    word_t      data;
  } exp_t;

  localparam dtm_op_e   R  = DTM_READ;
  localparam dtm_op_e   W  = DTM_WRITE;
  localparam dtm_resp_e OK = DTM_SUCCESS;
  localparam dtm_resp_e BZ = DTM_BUSY;

  logic clk_i, rst_ni, dmi_rst_ni;
  logic dmi_req_valid_i, dmi_req_ready_o, dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_req_t  dmi_req_i;
  dmi_resp_t dmi_resp_o;
  logic ndmreset_o, dmactive_o, clear_resumeack_o, cmd_valid_o;
  hart_vec_t halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
  hartsel_t hartsel_o;
  command_t cmd_o;
  logic cmderror_valid_i, cmdbusy_i, data_valid_i;
  cmderr_e cmderror_i;
  word_t [ProgBufSize-1:0] progbuf_o;
  word_t [DataCount-1:0] data_o, data_i;

  test_t tests[$];
  exp_t  exp_q[$];
  int    test_errs[64];
  int    parts[64];
  int    err_count = 0;
  int    check_count = 0;
  int    in_flight = 0;
  logic  saw_stall = 1'b0;
  logic  table_ready = 1'b0;
  logic  dm_active = 1'b0;
  word_t last_cmd = '0;
  logic [31:0] lfsr = 32'h61a41cfc;

  dm_csrs_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // galois LFSR, one step per bit
  task automatic next_bit(output logic b);
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    b = lfsr[0];
  endtask

  task automatic add(input dtm_op_e op, input dmi_addr_t addr, input word_t wdata, input int busy,
                     input hart_vec_t halted, input hart_vec_t rack, input logic [3:0] herr,
                     input int hdv, input dtm_resp_e resp, input word_t data, input int cmd,
                     input int clr, input int chk, input hart_vec_t hreq, input hart_vec_t rreq);
    test_t t;
    t = '{op: op, addr: addr, wdata: wdata, busy: busy != 0, halted: halted, rack: rack,
          herr: herr, hdv: hdv != 0, resp: resp, data: data, cmd: cmd != 0, clr: clr != 0,
          chk_req: chk != 0, hreq: hreq, rreq: rreq};
    tests.push_back(t);
  endtask

  task automatic check_value(input int i, input string name, input word_t got, input word_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAILED test %0d %s: got %h expected %h", i, name, got, exp);
      err_count++;
      test_errs[i]++;
    end
  endtask

  // a test is done once both its side checks and its response are in
  task automatic finish_part(input int i);
    parts[i]++;
    if (parts[i] == 2) begin
      $display("test %0d finished, %0d errors", i, test_errs[i]);
    end
  endtask

  task automatic apply(input int i);
    test_t e;
    exp_t x;
    dmi_addr_t a;
    e = tests[i];
    a = e.addr;
    @(negedge clk_i);
    cmdbusy_i        = e.busy;
    halted_i         = e.halted;
    resumeack_i      = e.rack;
    cmderror_valid_i = e.herr[3];
    cmderror_i       = cmderr_e'(e.herr[2:0]);
    data_valid_i     = e.hdv;
    dmi_req_i        = '{addr: e.addr, op: e.op, data: e.wdata};
    dmi_req_valid_i  = 1'b1;
    while (!dmi_req_ready_o) @(negedge clk_i);
    x.idx  = 8'(i);
    x.resp = e.resp;
    x.data = e.data;
    exp_q.push_back(x);
    @(posedge clk_i);
    // stage cycle
    @(negedge clk_i);
    dmi_req_valid_i = 1'b0;
    check_value(i, "clear_resumeack_o", word_t'(clear_resumeack_o), word_t'(e.clr));
    check_value(i, "cmd_valid_o", word_t'(cmd_valid_o), 32'h0);
    @(posedge clk_i);
    @(negedge clk_i);
    check_value(i, "cmd_valid_o", word_t'(cmd_valid_o), word_t'(e.cmd));
    if (e.chk_req) begin
      check_value(i, "haltreq_o", word_t'(haltreq_o), word_t'(e.hreq));
      check_value(i, "resumereq_o", word_t'(resumereq_o), word_t'(e.rreq));
    end
    if (e.op == W && e.resp == OK && a >= 7'h04 && a <= 7'h05) begin
      check_value(i, "data_o", data_o[a - 7'h04], e.wdata);
    end
    if (e.op == W && e.resp == OK && a >= 7'h20 && a <= 7'h23) begin
      check_value(i, "progbuf_o", progbuf_o[a - 7'h20], e.wdata);
    end
    // an inactive module only takes dmactive from a write
    if (e.op == W && a == 7'h10) begin
      check_value(i, "dmactive_o", word_t'(dmactive_o), word_t'(e.wdata[0]));
      check_value(i, "ndmreset_o", word_t'(ndmreset_o),
                  dm_active ? word_t'(e.wdata[1]) : 32'h0);
      check_value(i, "hartsel_o", word_t'(hartsel_o),
                  dm_active ? word_t'(e.wdata[17:16]) : 32'h0);
      dm_active = e.wdata[0];
    end
    if (e.op == W && a == 7'h17 && e.resp == OK) begin
      last_cmd = e.wdata;
    end
    check_value(i, "cmd_o", word_t'(cmd_o), last_cmd);
    // command register clears on the edges after dmactive drops
    if (e.op == W && a == 7'h10 && !e.wdata[0]) begin
      last_cmd = '0;
    end
    finish_part(i);
  endtask

  // ------------------------------
  // response side
  // ------------------------------

  // requests accepted and not yet popped
  always @(posedge clk_i) begin
    in_flight <= in_flight + int'(dmi_req_valid_i & dmi_req_ready_o)
                 - int'(dmi_resp_valid_o & dmi_resp_ready_i);
  end

  initial begin
    logic b0, b1;
    exp_t x;
    dmi_resp_ready_i = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      next_bit(b0);
      next_bit(b1);
      dmi_resp_ready_i = b0 & b1;
      if (in_flight >= int'(RespDepth)) saw_stall = 1'b1;
      // every request in flight needs its own queue slot
      check_count++;
      assert (dmi_req_ready_o === (in_flight < int'(RespDepth))) else begin
        $display("FAILED dmi_req_ready_o: got %h expected %h", dmi_req_ready_o,
                 in_flight < int'(RespDepth));
        err_count++;
      end
      if (dmi_resp_valid_o && dmi_resp_ready_i) begin
        assert (exp_q.size() > 0) else begin
          $display("response arrived with no request outstanding");
          err_count++;
        end
        if (exp_q.size() > 0) begin
          x = exp_q.pop_front();
          check_value(int'(x.idx), "dmi_resp_o.resp", word_t'(dmi_resp_o.resp), word_t'(x.resp));
          check_value(int'(x.idx), "dmi_resp_o.data", dmi_resp_o.data, x.data);
          finish_part(int'(x.idx));
        end
      end
    end
  end

  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (tests.size() + 4) * 40;
    #(limit_ns);
    $display("timeout: the tests did not complete in %0d ns", limit_ns);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    dmi_rst_ni = 1'b1;
    dmi_req_valid_i = 1'b0;
    dmi_req_i = '0;
    halted_i = '0;
    unavailable_i = '0;
    resumeack_i = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i = CmdErrNone;
    cmdbusy_i = 1'b0;
    data_valid_i = 1'b0;
    data_i[0] = 32'h11112222;
    data_i[1] = 32'h0badcafe;

    //  op addr   wdata         bsy halted  rack    herr  hdv resp data       cmd clr chk hreq rreq
    add(R, 7'h11, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h000C0C82, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h10000001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h11, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h00000C82, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h80010001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 1, 3'b010, 3'b0);
    add(R, 7'h40, 32'h0,        0, 3'b010, 3'b000, 4'h0, 0, OK, 32'h2,        0, 0, 1, 3'b010, 3'b0);
    add(R, 7'h11, 32'h0,        0, 3'b010, 3'b000, 4'h0, 0, OK, 32'h000C0382, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h40010001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 1, 1, 3'b0, 3'b010);
    add(R, 7'h10, 32'h0,        0, 3'b000, 3'b010, 4'h0, 0, OK, 32'h00010001, 0, 0, 1, 3'b0, 3'b0);
    add(W, 7'h10, 32'h00030001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h11, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0000C082, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h00000001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    // data and program buffer
    add(W, 7'h04, 32'hdeadbeef, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h05, 32'h12345678, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h22, 32'hcafef00d, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h04, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'hdeadbeef, 0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h22, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'hcafef00d, 0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h05, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h12345678, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h18, 32'h1,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h18, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h1,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h04, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'hdeadbeef, 1, 0, 0, 3'b0, 3'b0);
    add(R, 7'h05, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h12345678, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h17, 32'h00221000, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        1, 0, 0, 3'b0, 3'b0);
    // busy and cmderr
    add(W, 7'h17, 32'h00221000, 1, 3'b000, 3'b000, 4'h0, 0, BZ, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h16, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h04000102, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h16, 32'h0,        0, 3'b000, 3'b000, 4'hB, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h16, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h04000302, 0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h16, 32'h700,      0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h16, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h04000002, 0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h05, 32'h0,        0, 3'b000, 3'b000, 4'h0, 1, OK, 32'h0badcafe, 0, 0, 0, 3'b0, 3'b0);
    // dmactive clear, then ndmreset
    add(W, 7'h10, 32'h00010001, 0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h04, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h22, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h10, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h1,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h3,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(W, 7'h10, 32'h1,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h0,        0, 0, 0, 3'b0, 3'b0);
    add(R, 7'h11, 32'h0,        0, 3'b000, 3'b000, 4'h0, 0, OK, 32'h000C0C82, 0, 0, 0, 3'b0, 3'b0);
    table_ready = 1'b1;

    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    for (int i = 0; i < tests.size(); i++) begin
      apply(i);
    end
    while (exp_q.size() != 0) @(negedge clk_i);
    @(negedge clk_i);

    assert (saw_stall) else begin
      $display("the response queue never filled up, so back-pressure was not exercised");
      err_count++;
    end
    $display("%0d tests, %0d checks, %0d errors", tests.size(), check_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
